// File: include/dcache_consts.svh
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ======================================================================
// data cache geometry
// ======================================================================

// sets, indexed by address bits 5:3
`define DC_SETS 8

// ways per set
`define DC_WAYS 2

// rows walked by the halt flush, sets times ways
// sized to match the flush row counter
`define DC_ROWS 5'd16

// word that receives the hit counter once the flush is done
`define DC_COUNT_ADDR 32'h0000_3100

`endif

// File: hw/cache_types_pkg.sv
package cache_types_pkg;

   // ======================================================================
   // address split
   // ======================================================================

   // tag is address bits 31:6
   typedef logic [25:0] tag_t;

   // set index is address bits 5:3
   typedef logic [2:0] set_idx_t;

   // 0-7 way 0, 8-15 way 1, 16 means the walk is over
   typedef logic [4:0] row_t;

   typedef logic way_t;

   // ======================================================================
   // controller
   // ======================================================================

   typedef enum logic [3:0] {
      IDLE, WB0, WB1, FILL0, FILL1, SCAN, FLUSH0, FLUSH1, COUNT, HALTED
   } dc_state_e;

   // what the memory port drives this cycle
   typedef enum logic [2:0] {
      OP_NONE,
      OP_WB,
      OP_FILL,
      OP_FLUSH,
      OP_COUNT
   } mem_op_e;

endpackage

// File: hw/mem_bus_pkg.sv
package mem_bus_pkg;

   // ======================================================================
   // memory bus
   // ======================================================================

   // one data word on either side of the cache
   typedef logic [31:0] word_t;

   // byte address, bits 1:0 always zero for word accesses
   typedef logic [31:0] addr_t;

endpackage

// File: hw/dcache_array.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_array (
   input  logic                      CLK,
   input  logic                      nRST,
   input  cache_types_pkg::set_idx_t set_idx,
   input  cache_types_pkg::way_t     wr_way,
   input  logic                      wr_word,
   input  logic                      tag_we,
   input  logic                      data_we,
   input  logic                      dirty_set,
   input  logic                      dirty_clr,
   input  cache_types_pkg::tag_t     wr_tag,
   input  mem_bus_pkg::word_t        wr_data,
   output cache_types_pkg::tag_t     tag0,
   output cache_types_pkg::tag_t     tag1,
   output logic                      valid0,
   output logic                      valid1,
   output logic                      dirty0,
   output logic                      dirty1,
   output mem_bus_pkg::word_t        data0_w0,
   output mem_bus_pkg::word_t        data0_w1,
   output mem_bus_pkg::word_t        data1_w0,
   output mem_bus_pkg::word_t        data1_w1
);

   cache_types_pkg::tag_t tag_mem [`DC_SETS][`DC_WAYS];
   mem_bus_pkg::word_t    data_mem [`DC_SETS][`DC_WAYS][2];

   logic [`DC_SETS-1:0][`DC_WAYS-1:0] valid_q;
   logic [`DC_SETS-1:0][`DC_WAYS-1:0] dirty_q;

   // ======================================================================
   // storage
   // ======================================================================

   always_ff @(posedge CLK)
   begin
      if (tag_we)
      begin
         tag_mem[set_idx][wr_way] <= wr_tag;
      end
      if (data_we)
      begin
         data_mem[set_idx][wr_way][wr_word] <= wr_data;
      end
   end

   // a tag write makes the way valid
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 0)
      begin
         valid_q <= '0;
         dirty_q <= '0;
      end
      else
      begin
         if (tag_we)
         begin
            valid_q[set_idx][wr_way] <= 1'b1;
         end
         if (dirty_clr)
         begin
            dirty_q[set_idx][wr_way] <= 1'b0;
         end
         else if (dirty_set)
         begin
            dirty_q[set_idx][wr_way] <= 1'b1;
         end
      end
   end

   // both ways of the selected set
   assign tag0     = tag_mem[set_idx][0];
   assign tag1     = tag_mem[set_idx][1];
   assign valid0   = valid_q[set_idx][0];
   assign valid1   = valid_q[set_idx][1];
   assign dirty0   = dirty_q[set_idx][0];
   assign dirty1   = dirty_q[set_idx][1];
   assign data0_w0 = data_mem[set_idx][0][0];
   assign data0_w1 = data_mem[set_idx][0][1];
   assign data1_w0 = data_mem[set_idx][1][0];
   assign data1_w1 = data_mem[set_idx][1][1];

endmodule

// File: hw/dcache_lookup.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_lookup (
   input  logic                      CLK,
   input  logic                      nRST,
   input  logic                      lookup_en,
   input  logic                      dmem_ren,
   input  logic                      dmem_wen,
   input  logic                      fill_done,
   input  cache_types_pkg::tag_t     req_tag,
   input  cache_types_pkg::set_idx_t set_idx,
   input  logic                      word_sel,
   input  cache_types_pkg::tag_t     tag0,
   input  cache_types_pkg::tag_t     tag1,
   input  logic                      valid0,
   input  logic                      valid1,
   input  logic                      dirty0,
   input  logic                      dirty1,
   input  mem_bus_pkg::word_t        data0_w0,
   input  mem_bus_pkg::word_t        data0_w1,
   input  mem_bus_pkg::word_t        data1_w0,
   input  mem_bus_pkg::word_t        data1_w1,
   output logic                      hit,
   output cache_types_pkg::way_t     hit_way,
   output cache_types_pkg::way_t     victim_way,
   output logic                      victim_dirty,
   output mem_bus_pkg::word_t        dmem_load,
   output mem_bus_pkg::word_t        hit_count
);

   logic req;
   logic match0;
   logic match1;

   // one bit per set naming the most recently used way
   logic [`DC_SETS-1:0] lru_q;

   assign req    = lookup_en && (dmem_ren || dmem_wen);
   assign match0 = valid0 && (tag0 == req_tag);
   assign match1 = valid1 && (tag1 == req_tag);
   assign hit    = req && (match0 || match1);

   assign hit_way      = match1;
   assign victim_way   = ~lru_q[set_idx];
   assign victim_dirty = victim_way ? dirty1 : dirty0;

   always_comb
   begin
      case ({hit_way, word_sel})
         2'b00:   dmem_load = data0_w0;
         2'b01:   dmem_load = data0_w1;
         2'b10:   dmem_load = data1_w0;
         default: dmem_load = data1_w1;
      endcase
   end

   // a miss costs one, the retry after the fill gives it back
   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 0)
      begin
         lru_q     <= '0;
         hit_count <= '0;
      end
      else
      begin
         if (hit)
         begin
            lru_q[set_idx] <= hit_way;
         end
         else if (fill_done)
         begin
            lru_q[set_idx] <= victim_way;
         end
         if (req)
         begin
            hit_count <= hit ? hit_count + 32'd1 : hit_count - 32'd1;
         end
      end
   end

endmodule

// File: hw/dcache_mem_port.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_mem_port (
   input  cache_types_pkg::mem_op_e  op,
   input  logic                      word_sel,
   input  cache_types_pkg::tag_t     req_tag,
   input  cache_types_pkg::set_idx_t set_idx,
   input  cache_types_pkg::tag_t     victim_tag,
   input  mem_bus_pkg::word_t        victim_w0,
   input  mem_bus_pkg::word_t        victim_w1,
   input  cache_types_pkg::row_t     flush_row,
   input  cache_types_pkg::tag_t     flush_tag,
   input  mem_bus_pkg::word_t        flush_w0,
   input  mem_bus_pkg::word_t        flush_w1,
   input  mem_bus_pkg::word_t        hit_count,
   output logic                      mem_ren,
   output logic                      mem_wen,
   output mem_bus_pkg::addr_t        mem_addr,
   output mem_bus_pkg::word_t        mem_store
);

   // word address inside a two-word block
   function automatic mem_bus_pkg::addr_t block_addr(
      input cache_types_pkg::tag_t     tag,
      input cache_types_pkg::set_idx_t set,
      input logic                      word
   );
      return {tag, set, word, 2'b00};
   endfunction

   assign mem_ren = (op == cache_types_pkg::OP_FILL);
   assign mem_wen = (op == cache_types_pkg::OP_WB) || (op == cache_types_pkg::OP_FLUSH) ||
                    (op == cache_types_pkg::OP_COUNT);

   always_comb
   begin
      mem_addr  = '0;
      mem_store = '0;
      case (op)
         cache_types_pkg::OP_WB:
         begin
            mem_addr  = block_addr(victim_tag, set_idx, word_sel);
            mem_store = word_sel ? victim_w1 : victim_w0;
         end
         cache_types_pkg::OP_FILL: mem_addr = block_addr(req_tag, set_idx, word_sel);
         cache_types_pkg::OP_FLUSH:
         begin
            mem_addr  = block_addr(flush_tag, flush_row[2:0], word_sel);
            mem_store = word_sel ? flush_w1 : flush_w0;
         end
         cache_types_pkg::OP_COUNT:
         begin
            mem_addr  = `DC_COUNT_ADDR;
            mem_store = hit_count;
         end
         default: ;
      endcase
   end

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_ctrl (
   input  logic                     CLK,
   input  logic                     nRST,
   input  logic                     dmem_ren,
   input  logic                     dmem_wen,
   input  logic                     halt,
   input  logic                     dwait,
   input  logic                     hit,
   input  logic                     victim_dirty,
   input  logic                     row_dirty,
   output logic                     lookup_en,
   output logic                     tag_we,
   output logic                     data_we,
   output logic                     dirty_set,
   output logic                     dirty_clr,
   output cache_types_pkg::way_t    fill_way,
   output cache_types_pkg::way_t    flush_way,
   output logic                     word_sel,
   output logic                     flushed,
   output logic                     set_sel_flush,
   output cache_types_pkg::row_t    flush_row,
   output cache_types_pkg::mem_op_e op
);

   cache_types_pkg::dc_state_e state;
   cache_types_pkg::dc_state_e next_state;
   cache_types_pkg::row_t      next_row;

   always_ff @(posedge CLK or negedge nRST)
   begin
      if (nRST == 0)
      begin
         state     <= cache_types_pkg::IDLE;
         flush_row <= '0;
      end
      else
      begin
         state     <= next_state;
         flush_row <= next_row;
      end
   end

   // ======================================================================
   // next state
   // ======================================================================

   always_comb
   begin
      next_state = state;
      next_row   = flush_row;
      case (state)
         cache_types_pkg::IDLE:
         begin
            if (halt)
            begin
               next_state = cache_types_pkg::SCAN;
               next_row   = '0;
            end
            else if ((dmem_ren || dmem_wen) && !hit)
            begin
               next_state = victim_dirty ? cache_types_pkg::WB0 : cache_types_pkg::FILL0;
            end
         end
         cache_types_pkg::WB0:    if (!dwait) next_state = cache_types_pkg::WB1;
         cache_types_pkg::WB1:    if (!dwait) next_state = cache_types_pkg::FILL0;
         cache_types_pkg::FILL0:  if (!dwait) next_state = cache_types_pkg::FILL1;
         cache_types_pkg::FILL1:  if (!dwait) next_state = cache_types_pkg::IDLE;
         // one cycle per row, dirty rows detour through the flush writes
         cache_types_pkg::SCAN:
         begin
            if (flush_row == `DC_ROWS)
               next_state = cache_types_pkg::COUNT;
            else if (row_dirty)
               next_state = cache_types_pkg::FLUSH0;
            else
               next_row = flush_row + 1'b1;
         end
         cache_types_pkg::FLUSH0: if (!dwait) next_state = cache_types_pkg::FLUSH1;
         cache_types_pkg::FLUSH1:
         begin
            if (!dwait)
            begin
               next_state = cache_types_pkg::SCAN;
               next_row   = flush_row + 1'b1;
            end
         end
         cache_types_pkg::COUNT:  if (!dwait) next_state = cache_types_pkg::HALTED;
         cache_types_pkg::HALTED: next_state = cache_types_pkg::HALTED;
         default:                 next_state = cache_types_pkg::IDLE;
      endcase
   end

   // ======================================================================
   // outputs
   // ======================================================================

   always_comb
   begin
      lookup_en     = 1'b0;
      tag_we        = 1'b0;
      data_we       = 1'b0;
      dirty_set     = 1'b0;
      dirty_clr     = 1'b0;
      fill_way      = 1'b0;
      word_sel      = 1'b0;
      set_sel_flush = 1'b0;
      op            = cache_types_pkg::OP_NONE;
      case (state)
         cache_types_pkg::IDLE:
         begin
            lookup_en = !halt;
            data_we   = hit && dmem_wen;
            dirty_set = hit && dmem_wen;
         end
         cache_types_pkg::WB0: op = cache_types_pkg::OP_WB;
         cache_types_pkg::WB1:
         begin
            op       = cache_types_pkg::OP_WB;
            word_sel = 1'b1;
         end
         // fill writes land in the victim way
         cache_types_pkg::FILL0:
         begin
            op       = cache_types_pkg::OP_FILL;
            fill_way = 1'b1;
            data_we  = !dwait;
         end
         cache_types_pkg::FILL1:
         begin
            op        = cache_types_pkg::OP_FILL;
            fill_way  = 1'b1;
            word_sel  = 1'b1;
            data_we   = !dwait;
            tag_we    = !dwait;
            dirty_clr = !dwait;
         end
         cache_types_pkg::SCAN: set_sel_flush = 1'b1;
         cache_types_pkg::FLUSH0:
         begin
            op            = cache_types_pkg::OP_FLUSH;
            set_sel_flush = 1'b1;
         end
         cache_types_pkg::FLUSH1:
         begin
            op            = cache_types_pkg::OP_FLUSH;
            set_sel_flush = 1'b1;
            word_sel      = 1'b1;
         end
         cache_types_pkg::COUNT: op = cache_types_pkg::OP_COUNT;
         default: ;
      endcase
   end

   assign flush_way = flush_row[3];
   assign flushed   = (state == cache_types_pkg::HALTED);

endmodule

// File: hw/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               dmem_ren,
   input  logic               dmem_wen,
   input  logic               halt,
   input  logic               dwait,
   input  mem_bus_pkg::addr_t dmem_addr,
   input  mem_bus_pkg::word_t dmem_store,
   input  mem_bus_pkg::word_t mem_load,
   output logic               dhit,
   output logic               flushed,
   output logic               mem_ren,
   output logic               mem_wen,
   output mem_bus_pkg::word_t dmem_load,
   output mem_bus_pkg::word_t mem_store,
   output mem_bus_pkg::addr_t mem_addr
);

   logic lookup_en, tag_we, data_we, dirty_set, dirty_clr, word_sel, set_sel_flush;
   logic hit, victim_dirty, row_dirty, wr_word;
   logic valid0, valid1, dirty0, dirty1;
   cache_types_pkg::way_t     fill_way, flush_way, hit_way, victim_way, wr_way;
   cache_types_pkg::row_t     flush_row;
   cache_types_pkg::mem_op_e  op;
   cache_types_pkg::set_idx_t set_idx;
   cache_types_pkg::tag_t     req_tag, tag0, tag1, victim_tag, flush_tag;
   mem_bus_pkg::word_t        data0_w0, data0_w1, data1_w0, data1_w1, hit_count, wr_data;
   mem_bus_pkg::word_t        victim_w0, victim_w1, flush_w0, flush_w1;

   assign req_tag = dmem_addr[31:6];
   assign set_idx = set_sel_flush ? flush_row[2:0] : dmem_addr[5:3];
   assign dhit    = hit;

   // fills take memory data into the victim, hits take the store word
   assign wr_way  = fill_way ? victim_way : hit_way;
   assign wr_word = (op == cache_types_pkg::OP_FILL) ? word_sel : dmem_addr[2];
   assign wr_data = (op == cache_types_pkg::OP_FILL) ? mem_load : dmem_store;

   assign victim_tag = victim_way ? tag1 : tag0;
   assign victim_w0  = victim_way ? data1_w0 : data0_w0;
   assign victim_w1  = victim_way ? data1_w1 : data0_w1;
   assign flush_tag  = flush_way ? tag1 : tag0;
   assign flush_w0   = flush_way ? data1_w0 : data0_w0;
   assign flush_w1   = flush_way ? data1_w1 : data0_w1;
   assign row_dirty  = flush_way ? dirty1 : dirty0;

   dcache_ctrl ctrl_i (.*);

   dcache_array array_i (.*, .wr_tag(req_tag));

   dcache_lookup lookup_i (.*, .fill_done(tag_we), .word_sel(dmem_addr[2]));

   dcache_mem_port mem_port_i (.*);

endmodule

// File: dv/tb_clkgen.sv
`timescale 1ns/1ns

module tb_clkgen (
   output logic CLK,
   output logic nRST
);

   // 8 ns period
   initial
   begin
      CLK = 1'b0;
      forever #4 CLK = ~CLK;
   end

   // reset held over the first three rising edges
   initial
   begin
      nRST = 1'b0;
      repeat (3) @(posedge CLK);
      nRST <= 1'b1;
   end

endmodule

// File: dv/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               mem_ren,
   input  logic               mem_wen,
   input  mem_bus_pkg::addr_t mem_addr,
   input  mem_bus_pkg::word_t mem_store,
   output logic               dwait,
   output mem_bus_pkg::word_t mem_load
);

   // 16 KB of words, byte addresses 0x0000 to 0x3fff
   mem_bus_pkg::word_t mem [4096];
   logic [1:0]         wait_cnt;
   logic               busy;
   logic               done;

   initial
   begin
      for (int i = 0; i < 4096; i++)
      begin
         mem[i[11:0]] = 32'hC0DE_0000 ^ {18'd0, i[11:0], 2'b00};
      end
   end

   assign busy     = mem_ren || mem_wen;
   assign done     = busy && (wait_cnt == 2'd0);
   assign dwait    = busy && (wait_cnt != 2'd0);
   assign mem_load = mem[mem_addr[13:2]];

   always @(posedge CLK or negedge nRST)
   begin
      if (nRST == 0)
         wait_cnt <= 2'd0;
      else if (done)
         wait_cnt <= 2'($urandom_range(3, 0));
      else if (busy)
         wait_cnt <= wait_cnt - 2'd1;
   end

   always @(posedge CLK)
   begin
      if (done && mem_wen)
         mem[mem_addr[13:2]] <= mem_store;
   end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_consts.svh"

module dcache_tb;

   localparam int N_ENTRIES    = 23;
   // lookup, write-back and fill of up to four cycles each, then the retry
   localparam int MISS_CYCLES  = 18;
   localparam int FLUSH_CYCLES = 200;
   localparam int TIMEOUT_NS   = (N_ENTRIES * MISS_CYCLES + FLUSH_CYCLES + 10) * 8;
   localparam logic [11:0] COUNT_IDX = 12'(`DC_COUNT_ADDR >> 2);

   typedef struct packed {
      logic               wr;
      mem_bus_pkg::addr_t addr;
      mem_bus_pkg::word_t data;
      mem_bus_pkg::word_t load;
   } entry_t;

   logic               CLK;
   logic               nRST;
   logic               dmem_ren;
   logic               dmem_wen;
   logic               halt;
   logic               dwait;
   logic               dhit;
   logic               flushed;
   logic               mem_ren;
   logic               mem_wen;
   mem_bus_pkg::addr_t dmem_addr;
   mem_bus_pkg::addr_t mem_addr;
   mem_bus_pkg::word_t dmem_store;
   mem_bus_pkg::word_t dmem_load;
   mem_bus_pkg::word_t mem_load;
   mem_bus_pkg::word_t mem_store;

   // write, byte address, store data, expected load (reads only)
   entry_t stim [N_ENTRIES] = '{
      '{1'b0, 32'h0000_0000, 32'h0000_0000, 32'hC0DE_0000},
      '{1'b0, 32'h0000_0000, 32'h0000_0000, 32'hC0DE_0000},
      '{1'b1, 32'h0000_0004, 32'h1111_0004, 32'h0000_0000},
      '{1'b1, 32'h0000_0000, 32'h1111_0000, 32'h0000_0000},
      '{1'b0, 32'h0000_0004, 32'h0000_0000, 32'h1111_0004},
      '{1'b0, 32'h0000_0040, 32'h0000_0000, 32'hC0DE_0040},
      '{1'b1, 32'h0000_0044, 32'h2222_0044, 32'h0000_0000},
      // third tag in set 0 pushes out the dirty block at 0x000
      '{1'b0, 32'h0000_0080, 32'h0000_0000, 32'hC0DE_0080},
      '{1'b0, 32'h0000_0040, 32'h0000_0000, 32'hC0DE_0040},
      '{1'b0, 32'h0000_00C0, 32'h0000_0000, 32'hC0DE_00C0},
      '{1'b0, 32'h0000_0000, 32'h0000_0000, 32'h1111_0000},
      '{1'b0, 32'h0000_0004, 32'h0000_0000, 32'h1111_0004},
      '{1'b0, 32'h0000_0044, 32'h0000_0000, 32'h2222_0044},
      // set 1, write misses
      '{1'b1, 32'h0000_000C, 32'h3333_000C, 32'h0000_0000},
      '{1'b1, 32'h0000_0048, 32'h3333_0048, 32'h0000_0000},
      '{1'b0, 32'h0000_000C, 32'h0000_0000, 32'h3333_000C},
      '{1'b0, 32'h0000_0088, 32'h0000_0000, 32'hC0DE_0088},
      '{1'b0, 32'h0000_004C, 32'h0000_0000, 32'hC0DE_004C},
      '{1'b0, 32'h0000_0048, 32'h0000_0000, 32'h3333_0048},
      // left dirty for the flush
      '{1'b1, 32'h0000_1F38, 32'h4444_1F38, 32'h0000_0000},
      '{1'b1, 32'h0000_2F38, 32'h4444_2F38, 32'h0000_0000},
      '{1'b0, 32'h0000_1F3C, 32'h0000_0000, 32'hC0DE_1F3C},
      '{1'b1, 32'h0000_0010, 32'h5555_0010, 32'h0000_0000}
   };

   // reference tags, LRU and memory
   cache_types_pkg::tag_t ref_tag   [`DC_SETS][`DC_WAYS];
   logic                  ref_valid [`DC_SETS][`DC_WAYS] = '{default: '0};
   logic                  ref_dirty [`DC_SETS][`DC_WAYS] = '{default: '0};
   logic                  ref_mru   [`DC_SETS] = '{default: '0};
   mem_bus_pkg::word_t    ref_mem   [mem_bus_pkg::addr_t];

   int errors;
   int checks;
   int ref_hits;

   tb_clkgen clkgen_i (.CLK(CLK), .nRST(nRST));

   dcache_top dut_i (.*);

   tb_mem_model mem_i (.*);

   // ======================================================================
   // reference model and checks
   // ======================================================================

   function automatic mem_bus_pkg::word_t model_word(input mem_bus_pkg::addr_t a);
      if (ref_mem.exists(a))
         return ref_mem[a];
      return 32'hC0DE_0000 ^ a;
   endfunction

   task automatic ref_access(input entry_t e, output logic hit, output logic evict,
                             output mem_bus_pkg::addr_t evict_addr);
      cache_types_pkg::set_idx_t s;
      cache_types_pkg::tag_t     t;
      cache_types_pkg::way_t     w;
      s          = e.addr[5:3];
      t          = e.addr[31:6];
      hit        = 1'b1;
      evict      = 1'b0;
      evict_addr = '0;
      if (ref_valid[s][1'b0] && ref_tag[s][1'b0] == t)
         w = 1'b0;
      else if (ref_valid[s][1'b1] && ref_tag[s][1'b1] == t)
         w = 1'b1;
      else
      begin
         // miss replaces the least recently used way
         hit             = 1'b0;
         w               = ~ref_mru[s];
         evict           = ref_valid[s][w] && ref_dirty[s][w];
         evict_addr      = {ref_tag[s][w], s, 3'b000};
         ref_tag[s][w]   = t;
         ref_valid[s][w] = 1'b1;
         ref_dirty[s][w] = 1'b0;
      end
      ref_mru[s] = w;
      if (hit)
         ref_hits++;
      if (e.wr)
      begin
         ref_dirty[s][w] = 1'b1;
         ref_mem[e.addr] = e.data;
      end
   endtask

   task automatic check_value(input string name, input mem_bus_pkg::word_t got,
                              input mem_bus_pkg::word_t exp);
      checks++;
      assert (got == exp)
      else
      begin
         $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_mem_word(input mem_bus_pkg::addr_t a);
      check_value($sformatf("mem[%h]", a), mem_i.mem[a[13:2]], model_word(a));
   endtask

   task automatic apply_entry(input entry_t e);
      logic               exp_hit;
      logic               evict;
      mem_bus_pkg::addr_t evict_addr;
      ref_access(e, exp_hit, evict, evict_addr);
      dmem_ren   <= !e.wr;
      dmem_wen   <= e.wr;
      dmem_addr  <= e.addr;
      dmem_store <= e.data;
      @(negedge CLK);
      // a resident block answers in the cycle of the request
      check_value("dhit", 32'(dhit), 32'(exp_hit));
      while (!dhit)
         @(negedge CLK);
      if (!e.wr)
         check_value("dmem_load", dmem_load, e.load);
      @(posedge CLK);
      if (evict)
      begin
         check_mem_word(evict_addr);
         check_mem_word(evict_addr + 32'd4);
      end
   endtask

   // ======================================================================
   // main sequence
   // ======================================================================

   initial
   begin
      void'($urandom(77341));
      errors     = 0;
      checks     = 0;
      ref_hits   = 0;
      dmem_ren   = 1'b0;
      dmem_wen   = 1'b0;
      halt       = 1'b0;
      dmem_addr  = '0;
      dmem_store = '0;
      @(posedge nRST);
      @(posedge CLK);
      for (int i = 0; i < N_ENTRIES; i++)
      begin
         apply_entry(stim[i[4:0]]);
      end
      dmem_ren <= 1'b0;
      dmem_wen <= 1'b0;
      halt     <= 1'b1;
      @(negedge CLK);
      while (!flushed)
         @(negedge CLK);
      repeat (3)
      begin
         @(negedge CLK);
         check_value("flushed", 32'(flushed), 32'd1);
      end
      // every written word has reached memory
      foreach (ref_mem[a])
         check_mem_word(a);
      check_value("hit count word", mem_i.mem[COUNT_IDX], ref_hits);
      $display("summary: %0d checks, %0d errors, %0d hits on arrival", checks, errors,
               ref_hits);
      if (errors == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout: cache did not finish the requests and the flush in %0d ns",
               TIMEOUT_NS);
      $display("CHECKS FAILED");
      $finish;
   end

endmodule

// File: tb.f
+incdir+include
hw/cache_types_pkg.sv
hw/mem_bus_pkg.sv
hw/dcache_array.sv
hw/dcache_lookup.sv
hw/dcache_mem_port.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/tb_clkgen.sv
dv/tb_mem_model.sv
dv/dcache_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module dcache_tb -f tb.f -o dcache_sim

sim_out=$(./obj_dir/dcache_sim)
echo "$sim_out"

if echo "$sim_out" | grep -qx "ALL CHECKS PASSED"; then
   exit 0
fi
exit 1
